// ==== testbench/dmem_patterns.mem ====
// kind_addr_data_sel_expected; kind 0 core op with opcode in sel, 1 WB write, 2 WB read
// 3 btn set, 4 sw set, 5 led check, 6 test start with number in data, F end
6_0000_00000002_0_00000000
0_0000_11223344_8_00000000
0_0FFC_A5A55A5A_8_00000000
0_0010_DEADBEEF_8_00000000
0_100C_FFFFFFFF_8_00000000
0_0000_00000000_3_11223344
0_0FFC_00000000_3_A5A55A5A
0_0010_00000000_3_DEADBEEF
0_100C_00000000_3_00000000
0_1FFC_00000000_3_00000000
6_0000_00000003_0_00000000
0_0020_11223344_8_00000000
0_0020_777777AA_6_00000000
0_0021_000000BB_6_00000000
0_0022_123456CC_6_00000000
0_0023_FFFFFFDD_6_00000000
0_0020_00000000_3_DDCCBBAA
0_0021_00000000_1_FFFFFFBB
0_0023_00000000_1_FFFFFFDD
0_0021_00000000_4_000000BB
0_0020_00000000_2_FFFFBBAA
0_0022_00000000_5_0000DDCC
0_0024_00000000_8_00000000
0_0024_12348765_7_00000000
0_0025_00001111_7_00000000
0_0026_0000F0F0_7_00000000
0_0027_FFFF7ABC_7_00000000
0_0024_00000000_3_7ABC1111
0_0026_00000000_2_00007ABC
0_0024_00000000_1_00000011
6_0000_00000004_0_00000000
5_0000_00000000_0_00000000
0_1008_12345675_8_00000000
5_0000_00000000_0_00000005
0_1008_0000000A_6_00000000
5_0000_00000000_0_0000000A
0_1009_000000FF_6_00000000
5_0000_00000000_0_0000000A
0_100A_000000C0_7_00000000
0_1008_00000000_3_00C0FF0A
3_0000_00000009_0_00000000
0_1000_00000000_3_00000009
4_0000_00000005_0_00000000
0_1004_00000000_3_00000005
6_0000_00000005_0_00000000
0_00C0_11111111_8_00000000
1_0030_AABBCCDD_5_00000000
0_00C0_00000000_3_11BB11DD
1_0030_99887766_A_00000000
0_00C0_00000000_3_99BB77DD
0_00C4_0BADC0DE_8_00000000
2_0031_00000000_0_0BADC0DE
0_00C6_00000055_6_00000000
2_0031_00000000_0_0B55C0DE
2_03FF_00000000_0_A5A55A5A
F_0000_00000000_0_00000000

// ==== src.f ====
verilog/dmem_pkg.sv
verilog/mem_port_if.sv
verilog/dual_port_ram.sv
verilog/datamem.sv
verilog/load_store_unit.sv
verilog/wb_dmem_bridge.sv
verilog/dmem_top.sv
testbench/tb_dmem_top.sv

// ==== Bender.yml ====
package:
  name: dmem

sources:
  - verilog/dmem_pkg.sv
  - verilog/mem_port_if.sv
  - verilog/dual_port_ram.sv
  - verilog/datamem.sv
  - verilog/load_store_unit.sv
  - verilog/wb_dmem_bridge.sv
  - verilog/dmem_top.sv
  - target: test
    files:
      - testbench/tb_dmem_top.sv

// ==== testbench/tb_dmem_top.sv ====
module tb_dmem_top
	import dmem_pkg::*;
();

	// Record is kind, address, data, sel, expected
	localparam int pat_depth = 64;
	localparam int wb_limit = 20;
	localparam int rand_ops = 200;
	localparam int win_words = 64;
	// Random traffic stays in a window the patterns never touch
	localparam logic [ram_addr_w-1:0] win_base = 10'h100;

	logic clk;
	logic nrst;
	ls_op_e ls_op;
	logic [byte_addr_w-1:0] byte_addr;
	logic [31:0] store_data;
	logic [31:0] load_data;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [ram_addr_w-1:0] wb_adr;
	logic [3:0] wb_sel;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic [3:0] btn;
	logic [2:0] sw;
	logic [3:0] led;

	logic [87:0] patterns [0:pat_depth-1];
	// RAM model of the random window
	logic [31:0] ref_ram [0:win_words-1];
	// LED pins as the core stores should have left them
	logic [3:0] ref_led;
	// Result the core side should still be holding
	logic [31:0] last_load;
	// Set once the bridge stops answering
	logic wb_dead;
	integer seed;
	int errors;
	int tests_run;
	int tests_failed;
	int cur_test;
	int test_start_errors;

	dmem_top UUT (.*);

	always #4 clk = ~clk;

	function automatic string test_name(input int n);
		case (n)
			1: return "reset state";
			2: return "core word access";
			3: return "byte and halfword lanes";
			4: return "board I/O registers";
			5: return "port sharing";
			default: return "random Wishbone traffic";
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("ERROR at time %0t: %s expected %h, actual %h", $time, name, exp, act);
		errors++;
	endtask

	task automatic start_test(input int n);
		cur_test = n;
		test_start_errors = errors;
	endtask

	task automatic finish_test();
		int n;
		n = errors - test_start_errors;
		tests_run++;
		if (n == 0) begin
			$display("Test %0d, %s: passed", cur_test, test_name(cur_test));
		end else begin
			tests_failed++;
			$display("Test %0d, %s: FAILED with %0d errors", cur_test, test_name(cur_test), n);
		end
		cur_test = 0;
	endtask

	// One core opcode, result checked one cycle later
	task automatic core_access(input ls_op_e op, input logic [byte_addr_w-1:0] addr,
			input logic [31:0] data, input logic [31:0] exp);
		@(negedge clk);
		ls_op = op;
		byte_addr = addr;
		store_data = data;
		// Only byte lane 0 reaches the pins
		if (addr[byte_addr_w-1:2] == io_led_addr) begin
			if (op == ls_sw || (op == ls_sh && !addr[1]) ||
					(op == ls_sb && addr[1:0] == 2'b00)) begin
				ref_led = data[3:0];
			end
		end
		@(negedge clk);
		if (op >= ls_lb && op <= ls_lhu) begin
			if (load_data !== exp) begin
				report_mismatch("load_data", exp, load_data);
			end
			last_load = exp;
		end else if (load_data !== last_load) begin
			// No load, so the old result must stay
			report_mismatch("load_data", last_load, load_data);
		end
		ls_op = ls_none;
	endtask

	// Classic cycle, request held until ack
	task automatic wb_transfer(input logic we, input logic [ram_addr_w-1:0] adr,
			input logic [3:0] sel, input logic [31:0] data, output logic [31:0] rdata,
			output logic ok);
		int cnt;
		ok = 1'b0;
		rdata = '0;
		if (!wb_dead) begin
			@(negedge clk);
			wb_cyc = 1'b1;
			wb_stb = 1'b1;
			wb_we = we;
			wb_adr = adr;
			wb_sel = sel;
			wb_dat_w = data;
			cnt = 0;
			@(negedge clk);
			while (!wb_ack && cnt < wb_limit) begin
				@(negedge clk);
				cnt++;
			end
			if (wb_ack) begin
				rdata = wb_dat_r;
				ok = 1'b1;
			end else begin
				$display("Wishbone cycle at word %h gave no Wishbone acknowledge", adr);
				errors++;
				wb_dead = 1'b1;
			end
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			wb_we = 1'b0;
		end
	endtask

	// Replay the directed records until the end marker
	task automatic run_patterns();
		logic [3:0] kind;
		logic [15:0] addr;
		logic [31:0] data;
		logic [3:0] sel;
		logic [31:0] exp;
		logic [31:0] rd;
		logic ok;
		logic done;
		int idx;
		idx = 0;
		done = 1'b0;
		while (!done && idx < pat_depth) begin
			{kind, addr, data, sel, exp} = patterns[idx];
			case (kind)
				4'h0: core_access(ls_op_e'(sel), addr[byte_addr_w-1:0], data, exp);
				4'h1: wb_transfer(1'b1, addr[ram_addr_w-1:0], sel, data, rd, ok);
				4'h2: begin
					wb_transfer(1'b0, addr[ram_addr_w-1:0], 4'hF, 32'h0, rd, ok);
					if (ok && rd !== exp) begin
						report_mismatch("wb_dat_r", exp, rd);
					end
				end
				4'h3: begin
					@(negedge clk);
					btn = data[3:0];
				end
				4'h4: begin
					@(negedge clk);
					sw = data[2:0];
				end
				4'h5: begin
					@(negedge clk);
					if (led !== exp[3:0]) begin
						report_mismatch("led", {28'h0, exp[3:0]}, {28'h0, led});
					end
				end
				4'h6: begin
					if (cur_test != 0) begin
						finish_test();
					end
					start_test(data);
				end
				4'hF: done = 1'b1;
				default: begin
					$display("Pattern record %0d is unreadable, the pattern file is missing or damaged",
						idx);
					errors++;
					done = 1'b1;
				end
			endcase
			idx++;
		end
		if (cur_test != 0) begin
			finish_test();
		end
	endtask

	task automatic run_random();
		int i;
		int w;
		int gap;
		logic [31:0] r;
		logic [31:0] data;
		logic [31:0] rd;
		logic [ram_addr_w-1:0] adr;
		logic [3:0] sel;
		logic we;
		logic ok;
		start_test(6);
		// Known contents first, each word built from its address
		for (w = 0; w < win_words; w++) begin
			adr = win_base + w;
			data = {adr, ~adr, adr[5:0], 6'h2C};
			ref_ram[w] = data;
			wb_transfer(1'b1, adr, 4'hF, data, rd, ok);
		end
		for (i = 0; i < rand_ops; i++) begin
			r = $random(seed);
			gap = r[1:0];
			repeat (gap) @(negedge clk);
			r = $random(seed);
			we = r[0];
			sel = r[4:1];
			w = r[10:5];
			data = $random(seed);
			adr = win_base + w;
			wb_transfer(we, adr, we ? sel : 4'hF, data, rd, ok);
			if (we) begin
				for (int b = 0; b < 4; b++) begin
					if (sel[b]) begin
						ref_ram[w][8*b +: 8] = data[8*b +: 8];
					end
				end
			end else if (ok && rd !== ref_ram[w]) begin
				report_mismatch("wb_dat_r", ref_ram[w], rd);
			end
		end
		// Controller port cannot reach the LED register
		if (led !== ref_led) begin
			report_mismatch("led", {28'h0, ref_led}, {28'h0, led});
		end
		finish_test();
	endtask

	initial begin
		clk = 1'b0;
		nrst = 1'b0;
		ls_op = ls_none;
		byte_addr = '0;
		store_data = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_sel = '0;
		wb_dat_w = '0;
		btn = '0;
		sw = '0;
		seed = 44276;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cur_test = 0;
		test_start_errors = 0;
		last_load = '0;
		ref_led = 4'h0;
		wb_dead = 1'b0;
		$readmemh("testbench/dmem_patterns.mem", patterns);
		repeat (8) @(negedge clk);
		nrst = 1'b1;
		start_test(1);
		@(negedge clk);
		if (led !== 4'h0) begin
			report_mismatch("led", 32'h0, {28'h0, led});
		end
		if (wb_ack !== 1'b0) begin
			report_mismatch("wb_ack", 32'h0, {31'h0, wb_ack});
		end
		if (load_data !== 32'h0) begin
			report_mismatch("load_data", 32'h0, load_data);
		end
		finish_test();
		run_patterns();
		run_random();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== verilog/dmem_top.sv ====
module dmem_top
	import dmem_pkg::*;
(
	input logic clk,
	input logic nrst,

	// Core side
	input ls_op_e ls_op,
	input logic [byte_addr_w-1:0] byte_addr,
	input logic [31:0] store_data,
	output logic [31:0] load_data,

	// Wishbone classic slave
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [ram_addr_w-1:0] wb_adr,
	input logic [3:0] wb_sel,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,

	// Board pins
	input logic [3:0] btn,
	input logic [2:0] sw,
	output logic [3:0] led
);

	// Core to datamem
	mem_port_if core_port ();

	// Protocol controller to datamem
	mem_port_if con_port ();

	// Opcode to lanes and back
	load_store_unit u_lsu (
		.clk(clk),
		.nrst(nrst),
		.ls_op(ls_op),
		.byte_addr(byte_addr),
		.store_data(store_data),
		.load_data(load_data),
		.mem(core_port)
	);

	// Wishbone front end of the controller port
	wb_dmem_bridge u_wb (
		.clk(clk),
		.nrst(nrst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_sel(wb_sel),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.con(con_port)
	);

	// RAM, decode and board I/O
	datamem u_datamem (
		.clk(clk),
		.nrst(nrst),
		.core_port(core_port),
		.con_port(con_port),
		.btn(btn),
		.sw(sw),
		.led(led)
	);

endmodule

// ==== verilog/wb_dmem_bridge.sv ====
module wb_dmem_bridge
	import dmem_pkg::*;
(
	input logic clk,
	input logic nrst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [ram_addr_w-1:0] wb_adr,
	input logic [3:0] wb_sel,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	mem_port_if.master con
);

	// Idle, or acknowledging the request of the last cycle
	typedef enum logic {
		wb_idle,
		wb_pending
	} wb_state_e;

	wb_state_e state;

	// First cycle of a request
	logic req_start;

	assign req_start = wb_cyc && wb_stb && (state == wb_idle);

	// One cycle of ack after each request start
	always_ff @(posedge clk) begin
		if (!nrst) begin
			state <= wb_idle;
		end else if (req_start) begin
			state <= wb_pending;
		end else begin
			state <= wb_idle;
		end
	end

	assign wb_ack = (state == wb_pending);

	// Writes only on the start cycle, held requests are not rewritten
	assign con.we = (req_start && wb_we) ? wb_sel : 4'b0000;

	// Controller reaches the RAM only
	assign con.addr = {{(word_addr_w - ram_addr_w){1'b0}}, wb_adr};
	assign con.wdata = wb_dat_w;

	// RAM output is ready in the ack cycle
	assign wb_dat_r = con.rdata;

endmodule

// ==== verilog/load_store_unit.sv ====
module load_store_unit
	import dmem_pkg::*;
(
	input logic clk,
	input logic nrst,
	input ls_op_e ls_op,
	input logic [byte_addr_w-1:0] byte_addr,
	input logic [31:0] store_data,
	output logic [31:0] load_data,
	mem_port_if.master mem
);

	// Byte offset inside the word
	logic [1:0] offset;

	// Request state, aligned with the registered read
	ls_op_e op_q;
	logic [1:0] offset_q;

	// Extraction
	logic [7:0] load_byte;
	logic [15:0] load_half;
	logic [31:0] load_ext;

	// Last completed load result
	logic [31:0] load_hold;

	assign offset = byte_addr[1:0];
	assign mem.addr = byte_addr[byte_addr_w-1:2];

	// Store lane select and data replication
	always_comb begin
		mem.we = 4'b0000;
		mem.wdata = store_data;
		case (ls_op)
			ls_sb: begin
				mem.we = 4'b0001 << offset;
				mem.wdata = {4{store_data[7:0]}};
			end
			ls_sh: begin
				// Bit 0 of the offset is ignored for halfwords
				mem.we = offset[1] ? 4'b1100 : 4'b0011;
				mem.wdata = {2{store_data[15:0]}};
			end
			ls_sw: begin
				// Whole word, offset ignored
				mem.we = 4'b1111;
			end
			default: begin
				mem.we = 4'b0000;
			end
		endcase
	end

	// Opcode and offset wait for the RAM data
	always_ff @(posedge clk) begin
		if (!nrst) begin
			op_q <= ls_none;
			offset_q <= 2'b00;
			load_hold <= '0;
		end else begin
			op_q <= ls_op;
			offset_q <= offset;
			load_hold <= load_data;
		end
	end

	// Pick the addressed byte or halfword
	always_comb begin
		load_byte = mem.rdata[{offset_q, 3'b000} +: 8];
		load_half = offset_q[1] ? mem.rdata[31:16] : mem.rdata[15:0];
		case (op_q)
			ls_lb: load_ext = {{24{load_byte[7]}}, load_byte};
			ls_lh: load_ext = {{16{load_half[15]}}, load_half};
			ls_lbu: load_ext = {24'h0, load_byte};
			ls_lhu: load_ext = {16'h0, load_half};
			default: load_ext = mem.rdata;
		endcase
	end

	// New result right after a load, otherwise keep the old one
	assign load_data = ls_is_load(op_q) ? load_ext : load_hold;

endmodule

// ==== verilog/datamem.sv ====
module datamem
	import dmem_pkg::*;
(
	input logic clk,
	input logic nrst,
	mem_port_if.slave core_port,
	mem_port_if.slave con_port,
	input logic [3:0] btn,
	input logic [2:0] sw,
	output logic [3:0] led
);

	// Board I/O registers, full words
	logic [31:0] btn_q;
	logic [31:0] sw_q;
	logic [31:0] led_q;

	// Core address delayed to line up with the RAM output
	logic [word_addr_w-1:0] addr_q;
	logic core_in_ram;
	logic ram_hit_q;

	// Gated core side of the RAM
	mem_port_if ram_a ();

	// Words 0x000 to 0x3FF only
	assign core_in_ram = (core_port.addr < ram_depth);
	assign ram_hit_q = (addr_q < ram_depth);

	assign ram_a.we = core_in_ram ? core_port.we : 4'b0000;
	assign ram_a.addr = core_port.addr;
	assign ram_a.wdata = core_port.wdata;

	// Controller port goes straight to RAM port B
	dual_port_ram u_ram (
		.clk(clk),
		.a(ram_a),
		.b(con_port)
	);

	// Inputs resampled every edge, zero extended
	always_ff @(posedge clk) begin
		if (!nrst) begin
			btn_q <= '0;
			sw_q <= '0;
		end else begin
			btn_q <= {28'h0, btn};
			sw_q <= {29'h0, sw};
		end
	end

	// LED register takes byte lane stores
	always_ff @(posedge clk) begin
		if (!nrst) begin
			led_q <= '0;
		end else if (core_port.addr == io_led_addr) begin
			for (int i = 0; i < 4; i++) begin
				if (core_port.we[i]) begin
					led_q[8*i +: 8] <= core_port.wdata[8*i +: 8];
				end
			end
		end
	end

	assign led = led_q[3:0];

	// Address register for the read mux
	always_ff @(posedge clk) begin
		if (!nrst) begin
			addr_q <= '0;
		end else begin
			addr_q <= core_port.addr;
		end
	end

	// Core read mux, one cycle behind the address
	always_comb begin
		case (addr_q)
			io_btn_addr: core_port.rdata = btn_q;
			io_sw_addr: core_port.rdata = sw_q;
			io_led_addr: core_port.rdata = led_q;
			// Unmapped words read as zero
			default: core_port.rdata = ram_hit_q ? ram_a.rdata : 32'h0;
		endcase
	end

endmodule

// ==== verilog/dual_port_ram.sv ====
module dual_port_ram
	import dmem_pkg::*;
(
	input logic clk,
	mem_port_if.slave a,
	mem_port_if.slave b
);

	// Shared storage for both ports
	logic [31:0] mem [0:ram_depth-1];

	// Only the low bits index the array
	logic [ram_addr_w-1:0] a_addr;
	logic [ram_addr_w-1:0] b_addr;

	assign a_addr = a.addr[ram_addr_w-1:0];
	assign b_addr = b.addr[ram_addr_w-1:0];

	// Port A
	// Byte lane writes plus read-first output
	always @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (a.we[i]) begin
				mem[a_addr][8*i +: 8] <= a.wdata[8*i +: 8];
			end
		end
		// Old contents come out even when written
		a.rdata <= mem[a_addr];
	end

	// Port B
	// Same structure as port A, fully independent
	always @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (b.we[i]) begin
				mem[b_addr][8*i +: 8] <= b.wdata[8*i +: 8];
			end
		end
		b.rdata <= mem[b_addr];
	end

	// Same word written from both ports in one cycle
	// is left undefined, as in the block memory it replaces

endmodule

// ==== verilog/mem_port_if.sv ====
interface mem_port_if
	import dmem_pkg::*;
();

	// Byte lane write enables, bit i covers bits 8i+7..8i
	logic [3:0] we;

	// Word address
	logic [word_addr_w-1:0] addr;

	// Write data, already placed in its lanes
	logic [31:0] wdata;

	// Registered read data, one cycle after addr
	logic [31:0] rdata;

	// Requesting side
	modport master(output we, addr, wdata, input rdata);

	// Memory side
	modport slave(input we, addr, wdata, output rdata);

endinterface

// ==== verilog/dmem_pkg.sv ====
package dmem_pkg;

	// Core byte address spans the RAM and the I/O window
	localparam int byte_addr_w = 13;

	// Word address seen by the decoder
	localparam int word_addr_w = 11;

	// RAM word address and depth
	localparam int ram_addr_w = 10;
	localparam int ram_depth = 1 << ram_addr_w;

	// Board I/O words, just above the RAM
	localparam logic [word_addr_w-1:0] io_btn_addr = 11'h400;
	localparam logic [word_addr_w-1:0] io_sw_addr = 11'h401;
	localparam logic [word_addr_w-1:0] io_led_addr = 11'h402;

	// Load/store opcodes from the core
	typedef enum logic [3:0] {
		ls_none = 4'd0,
		// Loads
		ls_lb = 4'd1,
		ls_lh = 4'd2,
		ls_lw = 4'd3,
		ls_lbu = 4'd4,
		ls_lhu = 4'd5,
		// Stores
		ls_sb = 4'd6,
		ls_sh = 4'd7,
		ls_sw = 4'd8
	} ls_op_e;

	// True for every load flavour
	function automatic logic ls_is_load(ls_op_e op);
		logic hit;
		case (op)
			ls_lb, ls_lh, ls_lw, ls_lbu, ls_lhu: hit = 1'b1;
			default: hit = 1'b0;
		endcase
		return hit;
	endfunction

endpackage
